//--- udp_macros.svh
// Protocol constants for the UDP/IP layer.
// Include in any file that needs the UDP protocol number or header sizes.
`ifndef UDP_MACROS_SVH
`define UDP_MACROS_SVH

// IP protocol number of UDP
`define UDP_PROTOCOL 8'h11

`define UDP_HDR_BYTES 8

`define IPV4_HDR_BYTES 20

`endif

//--- udp_pkg.sv
// Header and payload types shared by the UDP/IP layer RTL and its testbench.
// Compile this package ahead of every other source file.
package udp_pkg;

    // IPv4 header fields carried by this layer
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    // UDP header plus the IP fields that travel with it
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [7:0]  ttl;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    typedef struct packed {
        logic [7:0] tdata;
        logic       tlast;
        logic       tuser;
    } beat_t;

endpackage

//--- ip_proto_demux.sv
// Receive-side demux for IP frames.
// UDP frames go to the UDP parser, all other protocols to the external IP output.
`timescale 1ns/100ps
`include "udp_macros.svh"

module ip_proto_demux (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_hdr_valid,
    output logic             in_hdr_ready,
    input  udp_pkg::ip_hdr_t in_hdr,
    input  logic             in_valid,
    output logic             in_ready,
    input  udp_pkg::beat_t   in_beat,
    output logic             ip_hdr_valid,
    input  logic             ip_hdr_ready,
    output udp_pkg::ip_hdr_t ip_hdr,
    output logic             ip_valid,
    input  logic             ip_ready,
    output udp_pkg::beat_t   ip_beat,
    output logic             udp_hdr_valid,
    input  logic             udp_hdr_ready,
    output udp_pkg::ip_hdr_t udp_hdr,
    output logic             udp_valid,
    input  logic             udp_ready,
    output udp_pkg::beat_t   udp_beat
);
    logic hdr_is_udp;
    logic last_udp_q;
    logic cur_udp;
    logic sel_udp_q;
    logic sel_ip_q;
    logic last_xfer;

    assign hdr_is_udp = in_hdr.protocol == `UDP_PROTOCOL;
    // Route of the latest header, kept once the source drops hdr_valid
    assign cur_udp    = in_hdr_valid ? hdr_is_udp : last_udp_q;
    assign last_xfer  = in_valid && in_ready && in_beat.tlast;

    assign udp_hdr_valid = in_hdr_valid && hdr_is_udp;
    assign ip_hdr_valid  = in_hdr_valid && !hdr_is_udp;
    assign udp_hdr       = in_hdr;
    assign ip_hdr        = in_hdr;
    assign in_hdr_ready  = hdr_is_udp ? udp_hdr_ready : ip_hdr_ready;

    assign udp_valid = in_valid && sel_udp_q;
    assign ip_valid  = in_valid && sel_ip_q;
    assign udp_beat  = in_beat;
    assign ip_beat   = in_beat;
    assign in_ready  = (sel_udp_q && udp_ready) || (sel_ip_q && ip_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_udp_q <= 1'b0;
            sel_udp_q  <= 1'b0;
            sel_ip_q   <= 1'b0;
        end else begin
            if (in_hdr_valid) begin
                last_udp_q <= hdr_is_udp;
            end
            if (!in_valid) begin
                sel_udp_q <= 1'b0;
                sel_ip_q  <= 1'b0;
            end else if ((!sel_udp_q && !sel_ip_q) || last_xfer) begin
                sel_udp_q <= cur_udp;
                sel_ip_q  <= !cur_udp;
            end
        end
    end

    a_sel_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(sel_udp_q && sel_ip_q));

endmodule

//--- udp_rx_parse.sv
// Strips the 8-byte UDP header off an IP payload.
// Emits a UDP header with the IP fields, then forwards the rest of the payload.
// Frames that end inside the UDP header are dropped without output.
`timescale 1ns/100ps
`include "udp_macros.svh"

module udp_rx_parse (
    input  logic              clk,
    input  logic              rst,
    input  logic              ip_hdr_valid,
    output logic              ip_hdr_ready,
    input  udp_pkg::ip_hdr_t  ip_hdr,
    input  logic              in_valid,
    output logic              in_ready,
    input  udp_pkg::beat_t    in_beat,
    output logic              udp_hdr_valid,
    input  logic              udp_hdr_ready,
    output udp_pkg::udp_hdr_t udp_hdr,
    output logic              out_valid,
    input  logic              out_ready,
    output udp_pkg::beat_t    out_beat
);
    localparam logic [3:0] HDR_FULL = 4'(`UDP_HDR_BYTES);
    localparam logic [3:0] HDR_LAST = 4'(`UDP_HDR_BYTES - 1);

    logic             busy_q;
    logic [3:0]       cnt_q;
    logic [63:0]      shift_q;
    logic             hdr_valid_q;
    udp_pkg::ip_hdr_t ip_q;
    logic             collect;
    logic             forward;
    logic             ip_xfer;

    assign collect = busy_q && cnt_q != HDR_FULL;
    assign forward = busy_q && cnt_q == HDR_FULL && !hdr_valid_q;
    assign ip_xfer = ip_hdr_valid && ip_hdr_ready;

    assign ip_hdr_ready = !busy_q;
    assign in_ready     = collect || (forward && out_ready);
    assign out_valid    = forward && in_valid;
    assign out_beat     = in_beat;

    assign udp_hdr_valid       = hdr_valid_q;
    assign udp_hdr.dscp        = ip_q.dscp;
    assign udp_hdr.ecn         = ip_q.ecn;
    assign udp_hdr.ttl         = ip_q.ttl;
    assign udp_hdr.source_ip   = ip_q.source_ip;
    assign udp_hdr.dest_ip     = ip_q.dest_ip;
    // Big-endian, first byte received ends up on top
    assign udp_hdr.source_port = shift_q[63:48];
    assign udp_hdr.dest_port   = shift_q[47:32];
    assign udp_hdr.length      = shift_q[31:16];
    assign udp_hdr.checksum    = shift_q[15:0];

    always_ff @(posedge clk) begin
        if (ip_xfer) begin
            ip_q <= ip_hdr;
        end
        if (collect && in_valid) begin
            shift_q <= {shift_q[55:0], in_beat.tdata};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q      <= 1'b0;
            cnt_q       <= 4'd0;
            hdr_valid_q <= 1'b0;
        end else begin
            if (ip_xfer) begin
                busy_q <= 1'b1;
                cnt_q  <= 4'd0;
            end
            if (collect && in_valid) begin
                if (in_beat.tlast) begin
                    // Runt frame
                    busy_q <= 1'b0;
                end else begin
                    cnt_q <= cnt_q + 4'd1;
                    if (cnt_q == HDR_LAST) begin
                        hdr_valid_q <= 1'b1;
                    end
                end
            end
            if (hdr_valid_q && udp_hdr_ready) begin
                hdr_valid_q <= 1'b0;
            end
            if (out_valid && out_ready && in_beat.tlast) begin
                busy_q <= 1'b0;
            end
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        cnt_q <= HDR_FULL);

endmodule

//--- udp_tx_build.sv
// Wraps a UDP frame into an IP frame for transmit.
// Sends the IP header, then the 8 UDP header bytes big-endian, then the payload.
// The checksum field goes out as given on the input header.
`timescale 1ns/100ps
`include "udp_macros.svh"

module udp_tx_build (
    input  logic              clk,
    input  logic              rst,
    input  logic              udp_hdr_valid,
    output logic              udp_hdr_ready,
    input  udp_pkg::udp_hdr_t udp_hdr,
    input  logic              in_valid,
    output logic              in_ready,
    input  udp_pkg::beat_t    in_beat,
    output logic              ip_hdr_valid,
    input  logic              ip_hdr_ready,
    output udp_pkg::ip_hdr_t  ip_hdr,
    output logic              out_valid,
    input  logic              out_ready,
    output udp_pkg::beat_t    out_beat
);
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_IP    = 2'd1;
    localparam logic [1:0] ST_BYTES = 2'd2;
    localparam logic [1:0] ST_PAY   = 2'd3;

    logic [1:0]        state_q;
    logic [2:0]        idx_q;
    udp_pkg::udp_hdr_t hdr_q;
    logic [63:0]       hdr_word;
    logic              byte_xfer;

    assign hdr_word  = {hdr_q.source_port, hdr_q.dest_port, hdr_q.length, hdr_q.checksum};
    assign byte_xfer = state_q == ST_BYTES && out_ready;

    assign udp_hdr_ready = state_q == ST_IDLE;
    assign ip_hdr_valid  = state_q == ST_IP;

    assign ip_hdr.dscp      = hdr_q.dscp;
    assign ip_hdr.ecn       = hdr_q.ecn;
    assign ip_hdr.length    = hdr_q.length + 16'(`IPV4_HDR_BYTES);
    assign ip_hdr.ttl       = hdr_q.ttl;
    assign ip_hdr.protocol  = `UDP_PROTOCOL;
    assign ip_hdr.source_ip = hdr_q.source_ip;
    assign ip_hdr.dest_ip   = hdr_q.dest_ip;

    always_comb begin
        out_valid = 1'b0;
        in_ready  = 1'b0;
        out_beat  = in_beat;
        if (state_q == ST_BYTES) begin
            out_valid      = 1'b1;
            out_beat.tdata = hdr_word[{3'd7 - idx_q, 3'b000} +: 8];
            out_beat.tlast = 1'b0;
            out_beat.tuser = 1'b0;
        end else if (state_q == ST_PAY) begin
            out_valid = in_valid;
            in_ready  = out_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (udp_hdr_valid && udp_hdr_ready) begin
            hdr_q <= udp_hdr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            idx_q   <= 3'd0;
        end else begin
            case (state_q)
                ST_IDLE: if (udp_hdr_valid) state_q <= ST_IP;
                ST_IP: begin
                    idx_q <= 3'd0;
                    if (ip_hdr_ready) state_q <= ST_BYTES;
                end
                ST_BYTES: begin
                    if (byte_xfer) begin
                        idx_q <= idx_q + 3'd1;
                        if (idx_q == 3'd7) state_q <= ST_PAY;
                    end
                end
                default: if (in_valid && out_ready && in_beat.tlast) state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- ip_tx_arbiter.sv
// Fixed-priority arbiter for two IP transmit streams with input 0 first.
// One input owns the output from its header until its payload tlast.
`timescale 1ns/100ps

module ip_tx_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             in_hdr_valid,
    output logic [1:0]             in_hdr_ready,
    input  udp_pkg::ip_hdr_t [1:0] in_hdr,
    input  logic [1:0]             in_valid,
    output logic [1:0]             in_ready,
    input  udp_pkg::beat_t [1:0]   in_beat,
    output logic                   out_hdr_valid,
    input  logic                   out_hdr_ready,
    output udp_pkg::ip_hdr_t       out_hdr,
    output logic                   out_valid,
    input  logic                   out_ready,
    output udp_pkg::beat_t         out_beat
);
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_HDR  = 2'd1;
    localparam logic [1:0] ST_PAY  = 2'd2;

    logic [1:0] state_q;
    logic       grant_q;
    logic       pick;
    logic       sel;
    logic       hdr_xfer;
    logic       last_xfer;

    assign pick = !in_hdr_valid[0];
    // Grant locks once a header is on the output
    assign sel  = state_q == ST_IDLE ? pick : grant_q;

    assign out_hdr_valid = state_q != ST_PAY && in_hdr_valid[sel];
    assign out_hdr       = in_hdr[sel];
    assign out_valid     = state_q == ST_PAY && in_valid[sel];
    assign out_beat      = in_beat[sel];
    assign hdr_xfer      = out_hdr_valid && out_hdr_ready;
    assign last_xfer     = out_valid && out_ready && out_beat.tlast;

    always_comb begin
        in_hdr_ready = 2'b00;
        in_ready     = 2'b00;
        in_hdr_ready[sel] = state_q != ST_PAY && out_hdr_ready;
        in_ready[sel]     = state_q == ST_PAY && out_ready;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            grant_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    grant_q <= pick;
                    if (hdr_xfer) state_q <= ST_PAY;
                    else if (|in_hdr_valid) state_q <= ST_HDR;
                end
                ST_HDR: if (hdr_xfer) state_q <= ST_PAY;
                default: if (last_xfer) state_q <= ST_IDLE;
            endcase
        end
    end

    // Steering stays on one input from its header transfer up to its tlast transfer
    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        (hdr_xfer || (state_q == ST_PAY && !last_xfer)) |=> $stable(sel));

endmodule

//--- udp_ip_core.sv
// UDP layer on top of an IPv4 stack.
// Receive: rx_ip splits into ip_out and parsed udp_out frames.
// Transmit: udp_in frames are wrapped and merged with ip_in onto tx_ip.
`timescale 1ns/100ps

module udp_ip_core (
    input  logic clk,
    input  logic rst,
    input  logic rx_ip_hdr_valid,
    output logic rx_ip_hdr_ready,
    input  udp_pkg::ip_hdr_t rx_ip_hdr,
    input  logic rx_ip_valid,
    output logic rx_ip_ready,
    input  udp_pkg::beat_t rx_ip_beat,
    output logic ip_out_hdr_valid,
    input  logic ip_out_hdr_ready,
    output udp_pkg::ip_hdr_t ip_out_hdr,
    output logic ip_out_valid,
    input  logic ip_out_ready,
    output udp_pkg::beat_t ip_out_beat,
    output logic udp_out_hdr_valid,
    input  logic udp_out_hdr_ready,
    output udp_pkg::udp_hdr_t udp_out_hdr,
    output logic udp_out_valid,
    input  logic udp_out_ready,
    output udp_pkg::beat_t udp_out_beat,
    input  logic udp_in_hdr_valid,
    output logic udp_in_hdr_ready,
    input  udp_pkg::udp_hdr_t udp_in_hdr,
    input  logic udp_in_valid,
    output logic udp_in_ready,
    input  udp_pkg::beat_t udp_in_beat,
    input  logic ip_in_hdr_valid,
    output logic ip_in_hdr_ready,
    input  udp_pkg::ip_hdr_t ip_in_hdr,
    input  logic ip_in_valid,
    output logic ip_in_ready,
    input  udp_pkg::beat_t ip_in_beat,
    output logic tx_ip_hdr_valid,
    input  logic tx_ip_hdr_ready,
    output udp_pkg::ip_hdr_t tx_ip_hdr,
    output logic tx_ip_valid,
    input  logic tx_ip_ready,
    output udp_pkg::beat_t tx_ip_beat
);
    // Demux to parser
    logic             parse_hdr_valid;
    logic             parse_hdr_ready;
    udp_pkg::ip_hdr_t parse_hdr;
    logic             parse_valid;
    logic             parse_ready;
    udp_pkg::beat_t   parse_beat;

    // Builder to arbiter input 0
    logic             build_hdr_valid;
    logic             build_hdr_ready;
    udp_pkg::ip_hdr_t build_hdr;
    logic             build_valid;
    logic             build_ready;
    udp_pkg::beat_t   build_beat;

    ip_proto_demux u_demux (
        .clk           (clk),
        .rst           (rst),
        .in_hdr_valid  (rx_ip_hdr_valid),
        .in_hdr_ready  (rx_ip_hdr_ready),
        .in_hdr        (rx_ip_hdr),
        .in_valid      (rx_ip_valid),
        .in_ready      (rx_ip_ready),
        .in_beat       (rx_ip_beat),
        .ip_hdr_valid  (ip_out_hdr_valid),
        .ip_hdr_ready  (ip_out_hdr_ready),
        .ip_hdr        (ip_out_hdr),
        .ip_valid      (ip_out_valid),
        .ip_ready      (ip_out_ready),
        .ip_beat       (ip_out_beat),
        .udp_hdr_valid (parse_hdr_valid),
        .udp_hdr_ready (parse_hdr_ready),
        .udp_hdr       (parse_hdr),
        .udp_valid     (parse_valid),
        .udp_ready     (parse_ready),
        .udp_beat      (parse_beat)
    );

    udp_rx_parse u_rx_parse (
        .clk           (clk),
        .rst           (rst),
        .ip_hdr_valid  (parse_hdr_valid),
        .ip_hdr_ready  (parse_hdr_ready),
        .ip_hdr        (parse_hdr),
        .in_valid      (parse_valid),
        .in_ready      (parse_ready),
        .in_beat       (parse_beat),
        .udp_hdr_valid (udp_out_hdr_valid),
        .udp_hdr_ready (udp_out_hdr_ready),
        .udp_hdr       (udp_out_hdr),
        .out_valid     (udp_out_valid),
        .out_ready     (udp_out_ready),
        .out_beat      (udp_out_beat)
    );

    udp_tx_build u_tx_build (
        .clk           (clk),
        .rst           (rst),
        .udp_hdr_valid (udp_in_hdr_valid),
        .udp_hdr_ready (udp_in_hdr_ready),
        .udp_hdr       (udp_in_hdr),
        .in_valid      (udp_in_valid),
        .in_ready      (udp_in_ready),
        .in_beat       (udp_in_beat),
        .ip_hdr_valid  (build_hdr_valid),
        .ip_hdr_ready  (build_hdr_ready),
        .ip_hdr        (build_hdr),
        .out_valid     (build_valid),
        .out_ready     (build_ready),
        .out_beat      (build_beat)
    );

    // UDP side on input 0 so it wins
    ip_tx_arbiter u_tx_arb (
        .clk           (clk),
        .rst           (rst),
        .in_hdr_valid  ({ip_in_hdr_valid, build_hdr_valid}),
        .in_hdr_ready  ({ip_in_hdr_ready, build_hdr_ready}),
        .in_hdr        ({ip_in_hdr, build_hdr}),
        .in_valid      ({ip_in_valid, build_valid}),
        .in_ready      ({ip_in_ready, build_ready}),
        .in_beat       ({ip_in_beat, build_beat}),
        .out_hdr_valid (tx_ip_hdr_valid),
        .out_hdr_ready (tx_ip_hdr_ready),
        .out_hdr       (tx_ip_hdr),
        .out_valid     (tx_ip_valid),
        .out_ready     (tx_ip_ready),
        .out_beat      (tx_ip_beat)
    );

endmodule

//--- tb_udp_ip_core.sv
// Testbench for the UDP layer core.
// Random frames from a fixed seed drive rx_ip, udp_in and ip_in with random
// valid gaps and output back-pressure; a model here predicts every output.
`timescale 1ns/100ps
`include "udp_macros.svh"

module tb_udp_ip_core;
    localparam int TIMEOUT = 2000;
    localparam int N_RX    = 300;
    localparam int N_UDP   = 150;
    localparam int N_IP    = 150;

    logic clk = 1'b0;
    logic rst;
    logic rx_ip_hdr_valid, rx_ip_hdr_ready, rx_ip_valid, rx_ip_ready;
    udp_pkg::ip_hdr_t rx_ip_hdr;
    udp_pkg::beat_t rx_ip_beat;
    logic ip_out_hdr_valid, ip_out_hdr_ready, ip_out_valid, ip_out_ready;
    udp_pkg::ip_hdr_t ip_out_hdr;
    udp_pkg::beat_t ip_out_beat;
    logic udp_out_hdr_valid, udp_out_hdr_ready, udp_out_valid, udp_out_ready;
    udp_pkg::udp_hdr_t udp_out_hdr;
    udp_pkg::beat_t udp_out_beat;
    logic udp_in_hdr_valid, udp_in_hdr_ready, udp_in_valid, udp_in_ready;
    udp_pkg::udp_hdr_t udp_in_hdr;
    udp_pkg::beat_t udp_in_beat;
    logic ip_in_hdr_valid, ip_in_hdr_ready, ip_in_valid, ip_in_ready;
    udp_pkg::ip_hdr_t ip_in_hdr;
    udp_pkg::beat_t ip_in_beat;
    logic tx_ip_hdr_valid, tx_ip_hdr_ready, tx_ip_valid, tx_ip_ready;
    udp_pkg::ip_hdr_t tx_ip_hdr;
    udp_pkg::beat_t tx_ip_beat;

    int errors = 0;
    int timeouts = 0;
    int checks = 0;

    // Expected traffic per output and per tx source
    udp_pkg::ip_hdr_t  exp_ipout_hdr[$];
    udp_pkg::beat_t    exp_ipout_beat[$];
    udp_pkg::udp_hdr_t exp_udp_hdr[$];
    udp_pkg::beat_t    exp_udp_beat[$];
    udp_pkg::ip_hdr_t  exp_tx0_hdr[$];
    udp_pkg::beat_t    exp_tx0_beat[$];
    udp_pkg::ip_hdr_t  exp_tx1_hdr[$];
    udp_pkg::beat_t    exp_tx1_beat[$];

    logic tx_in_frame = 1'b0;
    logic tx_src = 1'b0;

    always #4 clk = !clk;

    udp_ip_core u_dut (.*);

    function automatic udp_pkg::ip_hdr_t rand_ip_hdr();
        udp_pkg::ip_hdr_t h;
        h.dscp      = 6'($urandom);
        h.ecn       = 2'($urandom);
        h.length    = 16'($urandom);
        h.ttl       = 8'($urandom);
        h.protocol  = 8'($urandom);
        h.source_ip = $urandom;
        h.dest_ip   = $urandom;
        return h;
    endfunction

    function automatic logic [7:0] rand_protocol();
        logic [7:0] p;
        if ($urandom % 2 == 0) begin
            return `UDP_PROTOCOL;
        end
        p = 8'($urandom);
        while (p == `UDP_PROTOCOL) begin
            p = 8'($urandom);
        end
        return p;
    endfunction

    // 1 to 24 bytes with tlast on the final one
    function automatic void make_payload(ref udp_pkg::beat_t pay[$]);
        udp_pkg::beat_t b;
        int n;
        pay.delete();
        n = 1 + int'($urandom % 24);
        for (int i = 0; i < n; i++) begin
            b.tdata = 8'($urandom);
            b.tuser = 1'($urandom);
            b.tlast = (i == n - 1);
            pay.push_back(b);
        end
    endfunction

    function automatic logic ready_of(input int s, input logic hdr);
        case (s)
            0: return hdr ? rx_ip_hdr_ready : rx_ip_ready;
            1: return hdr ? udp_in_hdr_ready : udp_in_ready;
            default: return hdr ? ip_in_hdr_ready : ip_in_ready;
        endcase
    endfunction

    task automatic idle_gap();
        while ($urandom % 4 == 0) begin
            @(negedge clk);
        end
    endtask

    // Returns on the falling edge after the transfer
    task automatic hold_until_ready(input int s, input logic hdr, input string what);
        int t;
        t = 0;
        #3;
        while (!ready_of(s, hdr)) begin
            @(negedge clk);
            #3;
            t++;
            if (t > TIMEOUT) begin
                timeouts++;
                $display("timeout: %s was never accepted", what);
                return;
            end
        end
        @(negedge clk);
    endtask

    task automatic send_rx(input udp_pkg::ip_hdr_t h, input udp_pkg::beat_t pay[$]);
        @(negedge clk);
        idle_gap();
        rx_ip_hdr = h;
        rx_ip_hdr_valid = 1'b1;
        hold_until_ready(0, 1'b1, "rx_ip header");
        rx_ip_hdr_valid = 1'b0;
        if (timeouts != 0) return;
        foreach (pay[i]) begin
            idle_gap();
            rx_ip_beat = pay[i];
            rx_ip_valid = 1'b1;
            hold_until_ready(0, 1'b0, "rx_ip payload");
            rx_ip_valid = 1'b0;
            if (timeouts != 0) return;
        end
    endtask

    task automatic send_udp(input udp_pkg::udp_hdr_t h, input udp_pkg::beat_t pay[$]);
        @(negedge clk);
        idle_gap();
        udp_in_hdr = h;
        udp_in_hdr_valid = 1'b1;
        hold_until_ready(1, 1'b1, "udp_in header");
        udp_in_hdr_valid = 1'b0;
        if (timeouts != 0) return;
        foreach (pay[i]) begin
            idle_gap();
            udp_in_beat = pay[i];
            udp_in_valid = 1'b1;
            hold_until_ready(1, 1'b0, "udp_in payload");
            udp_in_valid = 1'b0;
            if (timeouts != 0) return;
        end
    endtask

    task automatic send_ip(input udp_pkg::ip_hdr_t h, input udp_pkg::beat_t pay[$]);
        @(negedge clk);
        idle_gap();
        ip_in_hdr = h;
        ip_in_hdr_valid = 1'b1;
        hold_until_ready(2, 1'b1, "ip_in header");
        ip_in_hdr_valid = 1'b0;
        if (timeouts != 0) return;
        foreach (pay[i]) begin
            idle_gap();
            ip_in_beat = pay[i];
            ip_in_valid = 1'b1;
            hold_until_ready(2, 1'b0, "ip_in payload");
            ip_in_valid = 1'b0;
            if (timeouts != 0) return;
        end
    endtask

    task automatic run_rx();
        udp_pkg::ip_hdr_t h;
        udp_pkg::udp_hdr_t u;
        udp_pkg::beat_t pay[$];
        for (int f = 0; f < N_RX; f++) begin
            if (timeouts != 0) break;
            h = rand_ip_hdr();
            h.protocol = rand_protocol();
            make_payload(pay);
            if (h.protocol != `UDP_PROTOCOL) begin
                exp_ipout_hdr.push_back(h);
                foreach (pay[i]) exp_ipout_beat.push_back(pay[i]);
            end else if (pay.size() > `UDP_HDR_BYTES) begin
                // A frame ending on the last header byte carries no payload and is dropped
                u.dscp        = h.dscp;
                u.ecn         = h.ecn;
                u.ttl         = h.ttl;
                u.source_ip   = h.source_ip;
                u.dest_ip     = h.dest_ip;
                u.source_port = {pay[0].tdata, pay[1].tdata};
                u.dest_port   = {pay[2].tdata, pay[3].tdata};
                u.length      = {pay[4].tdata, pay[5].tdata};
                u.checksum    = {pay[6].tdata, pay[7].tdata};
                exp_udp_hdr.push_back(u);
                for (int i = `UDP_HDR_BYTES; i < pay.size(); i++) begin
                    exp_udp_beat.push_back(pay[i]);
                end
            end
            send_rx(h, pay);
        end
    endtask

    task automatic run_udp();
        udp_pkg::udp_hdr_t u;
        udp_pkg::ip_hdr_t e;
        udp_pkg::beat_t pay[$];
        udp_pkg::beat_t b;
        logic [63:0] hb;
        for (int f = 0; f < N_UDP; f++) begin
            if (timeouts != 0) break;
            e = rand_ip_hdr();
            u.dscp        = e.dscp;
            u.ecn         = e.ecn;
            u.ttl         = e.ttl;
            u.source_ip   = e.source_ip;
            u.dest_ip     = e.dest_ip;
            u.source_port = 16'($urandom);
            u.dest_port   = 16'($urandom);
            u.length      = 16'($urandom);
            u.checksum    = 16'($urandom);
            make_payload(pay);
            e.protocol = `UDP_PROTOCOL;
            e.length   = u.length + 16'(`IPV4_HDR_BYTES);
            exp_tx0_hdr.push_back(e);
            hb = {u.source_port, u.dest_port, u.length, u.checksum};
            for (int k = 0; k < `UDP_HDR_BYTES; k++) begin
                b.tdata = hb[63 - 8 * k -: 8];
                b.tlast = 1'b0;
                b.tuser = 1'b0;
                exp_tx0_beat.push_back(b);
            end
            foreach (pay[i]) exp_tx0_beat.push_back(pay[i]);
            send_udp(u, pay);
        end
    endtask

    task automatic run_ip();
        udp_pkg::ip_hdr_t h;
        udp_pkg::beat_t pay[$];
        for (int f = 0; f < N_IP; f++) begin
            if (timeouts != 0) break;
            h = rand_ip_hdr();
            make_payload(pay);
            exp_tx1_hdr.push_back(h);
            foreach (pay[i]) exp_tx1_beat.push_back(pay[i]);
            send_ip(h, pay);
        end
    endtask

    function automatic void check_beat(input string name, input udp_pkg::beat_t got,
                                       ref udp_pkg::beat_t q[$]);
        udp_pkg::beat_t e;
        assert (q.size() != 0) else begin
            errors++;
            $display("%s delivered a payload beat that no frame predicts", name);
        end
        if (q.size() == 0) return;
        e = q.pop_front();
        checks++;
        assert (got == e) else begin
            errors++;
            $display("error: %s got %h expected %h", name, got, e);
        end
    endfunction

    // Header transfer with no frame left in the model
    function automatic logic frame_expected(input string name, input int pending);
        assert (pending != 0) else begin
            errors++;
            $display("%s delivered a header that no frame predicts", name);
        end
        return pending != 0;
    endfunction

    // Sample just before the rising edge where every output is settled
    always begin
        udp_pkg::ip_hdr_t eh;
        udp_pkg::udp_hdr_t eu;
        @(negedge clk);
        #3;
        if (ip_out_hdr_valid && ip_out_hdr_ready) begin
            if (frame_expected("ip_out", exp_ipout_hdr.size())) begin
                eh = exp_ipout_hdr.pop_front();
                checks++;
                assert (ip_out_hdr == eh) else begin
                    errors++;
                    $display("error: ip_out_hdr got %h expected %h", ip_out_hdr, eh);
                end
            end
        end
        if (ip_out_valid && ip_out_ready) check_beat("ip_out_beat", ip_out_beat, exp_ipout_beat);
        if (udp_out_hdr_valid && udp_out_hdr_ready) begin
            if (frame_expected("udp_out", exp_udp_hdr.size())) begin
                eu = exp_udp_hdr.pop_front();
                checks++;
                assert (udp_out_hdr == eu) else begin
                    errors++;
                    $display("error: udp_out_hdr got %h expected %h", udp_out_hdr, eu);
                end
            end
        end
        if (udp_out_valid && udp_out_ready) begin
            check_beat("udp_out_beat", udp_out_beat, exp_udp_beat);
        end
        if (tx_ip_valid && tx_ip_ready) begin
            assert (tx_in_frame) else begin
                errors++;
                $display("tx_ip payload beat arrived outside a frame");
            end
            if (tx_src) check_beat("tx_ip_beat", tx_ip_beat, exp_tx1_beat);
            else check_beat("tx_ip_beat", tx_ip_beat, exp_tx0_beat);
            if (tx_ip_beat.tlast) tx_in_frame = 1'b0;
        end
        if (tx_ip_hdr_valid && tx_ip_hdr_ready) begin
            assert (!tx_in_frame) else begin
                errors++;
                $display("tx_ip header arrived before the previous frame ended");
            end
            tx_in_frame = 1'b1;
            tx_src = u_dut.u_tx_arb.sel;
            if (frame_expected("tx_ip", tx_src ? exp_tx1_hdr.size() : exp_tx0_hdr.size())) begin
                eh = tx_src ? exp_tx1_hdr.pop_front() : exp_tx0_hdr.pop_front();
                checks++;
                assert (tx_ip_hdr == eh) else begin
                    errors++;
                    $display("error: tx_ip_hdr got %h expected %h", tx_ip_hdr, eh);
                end
            end
        end
    end

    // Output back-pressure
    always @(negedge clk) begin
        ip_out_hdr_ready  = $urandom % 4 != 0;
        ip_out_ready      = $urandom % 4 != 0;
        udp_out_hdr_ready = $urandom % 4 != 0;
        udp_out_ready     = $urandom % 4 != 0;
        tx_ip_hdr_ready   = $urandom % 4 != 0;
        tx_ip_ready       = $urandom % 4 != 0;
    end

    function automatic logic all_drained();
        return exp_ipout_hdr.size() == 0 && exp_ipout_beat.size() == 0
            && exp_udp_hdr.size() == 0 && exp_udp_beat.size() == 0
            && exp_tx0_hdr.size() == 0 && exp_tx0_beat.size() == 0
            && exp_tx1_hdr.size() == 0 && exp_tx1_beat.size() == 0;
    endfunction

    initial begin
        int t;
        void'($urandom(62));
        rst = 1'b1;
        rx_ip_hdr_valid = 1'b0;
        rx_ip_hdr = '0;
        rx_ip_valid = 1'b0;
        rx_ip_beat = '0;
        udp_in_hdr_valid = 1'b0;
        udp_in_hdr = '0;
        udp_in_valid = 1'b0;
        udp_in_beat = '0;
        ip_in_hdr_valid = 1'b0;
        ip_in_hdr = '0;
        ip_in_valid = 1'b0;
        ip_in_beat = '0;
        ip_out_hdr_ready = 1'b0;
        ip_out_ready = 1'b0;
        udp_out_hdr_ready = 1'b0;
        udp_out_ready = 1'b0;
        tx_ip_hdr_ready = 1'b0;
        tx_ip_ready = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fork
            run_rx();
            run_udp();
            run_ip();
        join

        t = 0;
        while (timeouts == 0 && !all_drained()) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                timeouts++;
                $display("timeout: expected frames never appeared on the outputs");
            end
        end

        $display("Checked %0d transfers: %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+.
udp_pkg.sv
ip_proto_demux.sv
udp_rx_parse.sv
udp_tx_build.sv
ip_tx_arbiter.sv
udp_ip_core.sv
tb_udp_ip_core.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_udp_ip_core
FILELIST  ?= build.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)
